/* husky_pkg.sv */
package husky_pkg;

   // Register bus
   localparam int unsigned REG_ADDR_W = 8;
   localparam int unsigned REG_DATA_W = 8;

   // Register map
   localparam logic [REG_ADDR_W-1:0] ADDR_ADC_READ     = 8'h03;  // FIFO data bypass
   localparam logic [REG_ADDR_W-1:0] ADDR_TARGET_CTRL  = 8'h24;
   localparam logic [REG_ADDR_W-1:0] ADDR_TARGET_OUT   = 8'h25;
   localparam logic [REG_ADDR_W-1:0] ADDR_ERROR_STATUS = 8'h26;  // Read-only and cleared by writing 1
   localparam logic [REG_ADDR_W-1:0] ADDR_LED_CTRL     = 8'h27;

   // Target control register bits
   localparam int unsigned CTRL_AVRPROG_BIT   = 0;
   localparam int unsigned CTRL_NRST_EN_BIT   = 1;
   localparam int unsigned CTRL_PDID_EN_BIT   = 2;
   localparam int unsigned CTRL_PDIC_EN_BIT   = 3;
   localparam int unsigned CTRL_POWER_OFF_BIT = 4;

   // Target output-value register bits
   localparam int unsigned OUT_NRST_BIT = 0;
   localparam int unsigned OUT_PDID_BIT = 1;
   localparam int unsigned OUT_PDIC_BIT = 2;

   // LED control register
   localparam int unsigned LED_GLITCH_BIT = 0;

   // Error sources are FIFO in bit 0, XADC in bit 1 and trace in bit 2
   localparam int unsigned ERR_W = 3;

   // Flash pattern is the counter MSB and toggles every 8 cycles
   localparam int unsigned FLASH_DIV_BITS = 4;

   // Target powered off out of reset
   localparam logic [REG_DATA_W-1:0] CTRL_RESET_VALUE = 8'h01 << CTRL_POWER_OFF_BIT;

endpackage

/* target_io_regs.sv */
`timescale 1ns/1ps

module target_io_regs (
   input  logic                             clk_usb_buf,
   input  logic                             rst_n_i,
   input  logic [husky_pkg::REG_ADDR_W-1:0] reg_address_i,
   input  logic [husky_pkg::REG_DATA_W-1:0] write_data_i,
   input  logic                             reg_write_i,
   output logic [husky_pkg::REG_DATA_W-1:0] read_data_o,
   output logic [husky_pkg::REG_DATA_W-1:0] ctrl_o,
   output logic [husky_pkg::REG_DATA_W-1:0] out_val_o
);

   import husky_pkg::*;

   logic                  sel_ctrl;
   logic                  sel_out;
   logic                  wr_ctrl;
   logic                  wr_out;
   logic [REG_DATA_W-1:0] ctrl_q;
   logic [REG_DATA_W-1:0] out_val_q;

   // Address decode
   assign sel_ctrl = (reg_address_i == ADDR_TARGET_CTRL);
   assign sel_out  = (reg_address_i == ADDR_TARGET_OUT);

   assign wr_ctrl = reg_write_i & sel_ctrl;
   assign wr_out  = reg_write_i & sel_out;

   // Enables, AVR programming and power-off
   always_ff @(posedge clk_usb_buf) begin
      if (!rst_n_i) begin
         ctrl_q <= CTRL_RESET_VALUE;  // Power-off set
      end else if (wr_ctrl) begin
         ctrl_q <= write_data_i;
      end
   end

   // Levels for nRST, PDID and PDIC when enabled
   always_ff @(posedge clk_usb_buf) begin
      if (!rst_n_i) begin
         out_val_q <= '0;
      end else if (wr_out) begin
         out_val_q <= write_data_i;
      end
   end

   // Read-back is zero outside this bank
   always_comb begin
      read_data_o = '0;
      if (sel_ctrl) begin
         read_data_o = ctrl_q;
      end else if (sel_out) begin
         read_data_o = out_val_q;
      end
   end

   assign ctrl_o    = ctrl_q;
   assign out_val_o = out_val_q;

endmodule

/* status_regs.sv */
`timescale 1ns/1ps

module status_regs (
   input  logic                             clk_usb_buf,
   input  logic                             rst_n_i,
   input  logic [husky_pkg::REG_ADDR_W-1:0] reg_address_i,
   input  logic [husky_pkg::REG_DATA_W-1:0] write_data_i,
   input  logic                             reg_write_i,
   input  logic [husky_pkg::ERR_W-1:0]      error_pulse_i,
   output logic [husky_pkg::REG_DATA_W-1:0] read_data_o,
   output logic                             error_any_o,
   output logic                             glitch_led_o
);

   import husky_pkg::*;

   logic                  sel_err;
   logic                  sel_led;
   logic [ERR_W-1:0]      err_clr;
   logic [ERR_W-1:0]      err_flags_q;
   logic [REG_DATA_W-1:0] led_ctrl_q;

   assign sel_err = (reg_address_i == ADDR_ERROR_STATUS);
   assign sel_led = (reg_address_i == ADDR_LED_CTRL);

   // Write of 1 clears the matching flag
   assign err_clr = (reg_write_i && sel_err) ? write_data_i[ERR_W-1:0] : '0;

   // Sticky flags where a new pulse beats a clear in the same cycle
   always_ff @(posedge clk_usb_buf) begin
      if (!rst_n_i) begin
         err_flags_q <= '0;
      end else begin
         err_flags_q <= (err_flags_q & ~err_clr) | error_pulse_i;
      end
   end

   always_ff @(posedge clk_usb_buf) begin
      if (!rst_n_i) begin
         led_ctrl_q <= '0;
      end else if (reg_write_i && sel_led) begin
         led_ctrl_q <= write_data_i;
      end
   end

   // Read-back
   always_comb begin
      read_data_o = '0;
      if (sel_err) begin
         read_data_o = REG_DATA_W'(err_flags_q);  // Upper bits read zero
      end else if (sel_led) begin
         read_data_o = led_ctrl_q;
      end
   end

   assign error_any_o  = |err_flags_q;
   assign glitch_led_o = led_ctrl_q[LED_GLITCH_BIT];

endmodule

/* read_combine.sv */
`timescale 1ns/1ps

module read_combine (
   input  logic                             clk_usb_buf,
   input  logic                             rst_n_i,
   input  logic [husky_pkg::REG_ADDR_W-1:0] reg_address_i,
   input  logic [husky_pkg::REG_DATA_W-1:0] target_rdata_i,
   input  logic [husky_pkg::REG_DATA_W-1:0] status_rdata_i,
   input  logic [husky_pkg::REG_DATA_W-1:0] fifo_dout_i,
   output logic [husky_pkg::REG_DATA_W-1:0] read_data_o
);

   import husky_pkg::*;

   logic [REG_DATA_W-1:0] rdata_q;

   // Banks drive zero when not addressed so a plain OR merges them
   always_ff @(posedge clk_usb_buf) begin
      if (!rst_n_i) begin
         rdata_q <= '0;
      end else begin
         rdata_q <= target_rdata_i | status_rdata_i;
      end
   end

   // Sample FIFO data bypasses the register stage
   assign read_data_o = (reg_address_i == ADDR_ADC_READ) ? fifo_dout_i : rdata_q;

endmodule

/* target_pin_router.sv */
`timescale 1ns/1ps

module target_pin_router (
   input  logic [husky_pkg::REG_DATA_W-1:0] ctrl_i,
   input  logic [husky_pkg::REG_DATA_W-1:0] out_val_i,
   input  logic                             usb_spare0_i,
   input  logic                             sam_mosi_i,
   input  logic                             sam_spck_i,
   input  logic                             target_miso_i,
   output logic                             target_nrst_o,
   output logic                             target_pdid_o,
   output logic                             target_pdic_o,
   output logic                             target_mosi_o,
   output logic                             target_sck_o,
   output logic                             sam_miso_o,
   output logic                             target_poweron_o
);

   import husky_pkg::*;

   logic avrprog;
   logic nrst_en;
   logic pdid_en;
   logic pdic_en;
   logic power_off;

   assign avrprog   = ctrl_i[CTRL_AVRPROG_BIT];
   assign nrst_en   = ctrl_i[CTRL_NRST_EN_BIT];
   assign pdid_en   = ctrl_i[CTRL_PDID_EN_BIT];
   assign pdic_en   = ctrl_i[CTRL_PDIC_EN_BIT];
   assign power_off = ctrl_i[CTRL_POWER_OFF_BIT];

   // Programmer pass-through has priority over the register level
   assign target_nrst_o = power_off ? 1'bz :
                          avrprog   ? usb_spare0_i :
                          nrst_en   ? out_val_i[OUT_NRST_BIT] : 1'bz;

   assign target_pdid_o = power_off ? 1'bz :
                          pdid_en   ? out_val_i[OUT_PDID_BIT] : 1'bz;

   assign target_pdic_o = power_off ? 1'bz :
                          pdic_en   ? out_val_i[OUT_PDIC_BIT] : 1'bz;

   // SPI lines from the SAM
   assign target_mosi_o = power_off ? 1'bz :
                          avrprog   ? sam_mosi_i : 1'bz;

   assign target_sck_o  = power_off ? 1'bz :
                          avrprog   ? sam_spck_i : 1'bz;

   // Return path, independent of target power
   assign sam_miso_o = avrprog ? target_miso_i : 1'bz;

   assign target_poweron_o = ~power_off;

endmodule

/* led_driver.sv */
`timescale 1ns/1ps

module led_driver (
   input  logic clk_usb_buf,
   input  logic rst_n_i,
   input  logic error_any_i,
   input  logic glitch_led_i,
   input  logic pll_status_i,
   input  logic led_cap_i,
   input  logic led_armed_i,
   output logic led_adc_o,
   output logic led_glitch_o,
   output logic led_cap_o,
   output logic led_armed_o
);

   import husky_pkg::*;

   logic [FLASH_DIV_BITS-1:0] flash_cnt_q;
   logic                      flash_pattern;

   // Free-running divider for the error flash
   always_ff @(posedge clk_usb_buf) begin
      if (!rst_n_i) begin
         flash_cnt_q <= '0;
      end else begin
         flash_cnt_q <= flash_cnt_q + 1'b1;
      end
   end

   assign flash_pattern = flash_cnt_q[FLASH_DIV_BITS-1];

   // Both red LEDs flash together while any error is pending
   assign led_adc_o    = error_any_i ? flash_pattern : ~pll_status_i;  // Lit on PLL unlock
   assign led_glitch_o = error_any_i ? flash_pattern : glitch_led_i;

   assign led_cap_o   = led_cap_i;
   assign led_armed_o = led_armed_i;

endmodule

/* husky_ctrl_top.sv */
`timescale 1ns/1ps

module husky_ctrl_top (
   input  logic                             clk_usb_buf,
   input  logic                             rst_n_i,
   // Register bus
   input  logic [husky_pkg::REG_ADDR_W-1:0] reg_address_i,
   input  logic [husky_pkg::REG_DATA_W-1:0] write_data_i,
   input  logic                             reg_write_i,
   input  logic                             reg_read_i,  // Reads decode by address alone
   output logic [husky_pkg::REG_DATA_W-1:0] read_data_o,
   input  logic [husky_pkg::REG_DATA_W-1:0] fifo_dout_i,
   input  logic [husky_pkg::ERR_W-1:0]      error_pulse_i,
   // Programming pins
   input  logic                             usb_spare0_i,
   input  logic                             sam_mosi_i,
   input  logic                             sam_spck_i,
   input  logic                             target_miso_i,
   output logic                             target_nrst_o,
   output logic                             target_pdid_o,
   output logic                             target_pdic_o,
   output logic                             target_mosi_o,
   output logic                             target_sck_o,
   output logic                             sam_miso_o,
   output logic                             target_poweron_o,
   // LEDs
   input  logic                             pll_status_i,
   input  logic                             led_cap_i,
   input  logic                             led_armed_i,
   output logic                             led_adc_o,
   output logic                             led_glitch_o,
   output logic                             led_cap_o,
   output logic                             led_armed_o
);

   import husky_pkg::*;

   logic [REG_DATA_W-1:0] target_rdata;
   logic [REG_DATA_W-1:0] status_rdata;
   logic [REG_DATA_W-1:0] target_ctrl;
   logic [REG_DATA_W-1:0] target_out_val;
   logic                  error_any;
   logic                  glitch_led;

   target_io_regs u_target_io_regs (
      .clk_usb_buf   (clk_usb_buf),
      .rst_n_i       (rst_n_i),
      .reg_address_i (reg_address_i),
      .write_data_i  (write_data_i),
      .reg_write_i   (reg_write_i),
      .read_data_o   (target_rdata),
      .ctrl_o        (target_ctrl),
      .out_val_o     (target_out_val)
   );

   status_regs u_status_regs (
      .clk_usb_buf   (clk_usb_buf),
      .rst_n_i       (rst_n_i),
      .reg_address_i (reg_address_i),
      .write_data_i  (write_data_i),
      .reg_write_i   (reg_write_i),
      .error_pulse_i (error_pulse_i),
      .read_data_o   (status_rdata),
      .error_any_o   (error_any),
      .glitch_led_o  (glitch_led)
   );

   read_combine u_read_combine (
      .clk_usb_buf    (clk_usb_buf),
      .rst_n_i        (rst_n_i),
      .reg_address_i  (reg_address_i),
      .target_rdata_i (target_rdata),
      .status_rdata_i (status_rdata),
      .fifo_dout_i    (fifo_dout_i),
      .read_data_o    (read_data_o)
   );

   target_pin_router u_target_pin_router (
      .ctrl_i           (target_ctrl),
      .out_val_i        (target_out_val),
      .usb_spare0_i     (usb_spare0_i),
      .sam_mosi_i       (sam_mosi_i),
      .sam_spck_i       (sam_spck_i),
      .target_miso_i    (target_miso_i),
      .target_nrst_o    (target_nrst_o),
      .target_pdid_o    (target_pdid_o),
      .target_pdic_o    (target_pdic_o),
      .target_mosi_o    (target_mosi_o),
      .target_sck_o     (target_sck_o),
      .sam_miso_o       (sam_miso_o),
      .target_poweron_o (target_poweron_o)
   );

   led_driver u_led_driver (
      .clk_usb_buf  (clk_usb_buf),
      .rst_n_i      (rst_n_i),
      .error_any_i  (error_any),
      .glitch_led_i (glitch_led),
      .pll_status_i (pll_status_i),
      .led_cap_i    (led_cap_i),
      .led_armed_i  (led_armed_i),
      .led_adc_o    (led_adc_o),
      .led_glitch_o (led_glitch_o),
      .led_cap_o    (led_cap_o),
      .led_armed_o  (led_armed_o)
   );

endmodule

/* tb_husky_ctrl.sv */
`timescale 1ns/1ps

module tb_husky_ctrl;

   import husky_pkg::*;

   localparam int unsigned STIM_DEPTH      = 256;
   localparam int unsigned CYCLES_PER_LINE = 40;
   localparam time         CLK_PERIOD      = 100ns;
   localparam time         DRIVE_DLY       = 10ns;

   // Opcodes of the stimulus file
   localparam logic [7:0] OP_WRITE      = 8'h01;
   localparam logic [7:0] OP_READ       = 8'h02;
   localparam logic [7:0] OP_PULSE_ERR  = 8'h03;
   localparam logic [7:0] OP_SET_PINS   = 8'h04;
   localparam logic [7:0] OP_CHECK_PINS = 8'h05;
   localparam logic [7:0] OP_CHECK_LED  = 8'h06;
   localparam logic [7:0] OP_END        = 8'hff;

   logic                  clk_usb_buf;
   logic                  rst_n;
   logic [REG_ADDR_W-1:0] reg_address;
   logic [REG_DATA_W-1:0] write_data;
   logic                  reg_write;
   logic                  reg_read;
   logic [REG_DATA_W-1:0] read_data;
   logic [REG_DATA_W-1:0] fifo_dout;
   logic [ERR_W-1:0]      error_pulse;
   logic                  usb_spare0;
   logic                  sam_mosi;
   logic                  sam_spck;
   logic                  target_miso;
   logic                  target_nrst;
   logic                  target_pdid;
   logic                  target_pdic;
   logic                  target_mosi;
   logic                  target_sck;
   logic                  sam_miso;
   logic                  target_poweron;
   logic                  pll_status;
   logic                  led_cap;
   logic                  led_armed;
   logic                  led_adc;
   logic                  led_glitch;
   logic                  led_cap_out;
   logic                  led_armed_out;

   logic [FLASH_DIV_BITS-1:0] flash_ref;

   logic [7:0]  stim_mem [0:STIM_DEPTH-1];
   int unsigned errors;
   int unsigned tests_failed;
   int unsigned cycles;
   int unsigned cycle_limit;

   husky_ctrl_top dut0 (
      .clk_usb_buf      (clk_usb_buf),
      .rst_n_i          (rst_n),
      .reg_address_i    (reg_address),
      .write_data_i     (write_data),
      .reg_write_i      (reg_write),
      .reg_read_i       (reg_read),
      .read_data_o      (read_data),
      .fifo_dout_i      (fifo_dout),
      .error_pulse_i    (error_pulse),
      .usb_spare0_i     (usb_spare0),
      .sam_mosi_i       (sam_mosi),
      .sam_spck_i       (sam_spck),
      .target_miso_i    (target_miso),
      .target_nrst_o    (target_nrst),
      .target_pdid_o    (target_pdid),
      .target_pdic_o    (target_pdic),
      .target_mosi_o    (target_mosi),
      .target_sck_o     (target_sck),
      .sam_miso_o       (sam_miso),
      .target_poweron_o (target_poweron),
      .pll_status_i     (pll_status),
      .led_cap_i        (led_cap),
      .led_armed_i      (led_armed),
      .led_adc_o        (led_adc),
      .led_glitch_o     (led_glitch),
      .led_cap_o        (led_cap_out),
      .led_armed_o      (led_armed_out)
   );

   initial begin
      clk_usb_buf = 1'b0;
      forever #(CLK_PERIOD / 2) clk_usb_buf = ~clk_usb_buf;
   end

   // Watchdog limit is set once the stimulus is loaded
   always @(posedge clk_usb_buf) begin
      cycles <= cycles + 1;
      if (cycle_limit != 0 && cycles >= cycle_limit) begin
         $display("Timeout: the run passed %0d cycles before the stimulus was done",
                  cycle_limit);
         $display("Simulation failed");
         $finish;
      end
   end

   // Reference count for the error flash pattern
   always @(posedge clk_usb_buf) begin
      if (!rst_n) begin
         flash_ref <= '0;
      end else begin
         flash_ref <= flash_ref + 1'b1;
      end
   end

   task automatic check_value(input string name, input logic [7:0] got, input logic [7:0] exp);
      assert (got === exp) else begin
         $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
         errors++;
      end
   endtask

   task automatic bus_write(input logic [7:0] addr, input logic [7:0] data);
      reg_address = addr;
      write_data  = data;
      reg_write   = 1'b1;
      @(posedge clk_usb_buf);
      #(DRIVE_DLY) reg_write = 1'b0;
   endtask

   task automatic bus_read(input logic [7:0] addr, input logic [7:0] exp);
      reg_address = addr;
      reg_read    = 1'b1;
      if (addr == ADDR_ADC_READ) begin
         @(negedge clk_usb_buf);  // Bypass path is combinational
         check_value("read_data_o", read_data, fifo_dout);
      end else begin
         @(posedge clk_usb_buf);  // Read-back register stage
         @(negedge clk_usb_buf);
         check_value("read_data_o", read_data, exp);
      end
   endtask

   task automatic pulse_error(input logic [7:0] bits);
      error_pulse = bits[ERR_W-1:0];
      @(posedge clk_usb_buf);
      #(DRIVE_DLY) error_pulse = '0;
   endtask

   task automatic drive_pins(input logic [7:0] bits);
      usb_spare0  = bits[0];
      sam_mosi    = bits[1];
      sam_spck    = bits[2];
      target_miso = bits[3];
      pll_status  = bits[4];
      led_cap     = bits[5];
      led_armed   = bits[6];
   endtask

   // A set mask bit means the pin must float
   task automatic check_pins(input logic [7:0] z_mask, input logic [7:0] vals);
      logic [6:0]  exp;
      int unsigned i;
      for (i = 0; i < 7; i++) begin
         exp[i] = z_mask[i] ? 1'bz : vals[i];
      end
      @(negedge clk_usb_buf);
      check_value("target_nrst_o", target_nrst, exp[0]);
      check_value("target_pdid_o", target_pdid, exp[1]);
      check_value("target_pdic_o", target_pdic, exp[2]);
      check_value("target_mosi_o", target_mosi, exp[3]);
      check_value("target_sck_o", target_sck, exp[4]);
      check_value("sam_miso_o", sam_miso, exp[5]);
      check_value("target_poweron_o", target_poweron, exp[6]);
   endtask

   task automatic check_flash();
      logic        prev;
      int unsigned toggles;
      toggles = 0;
      @(negedge clk_usb_buf);
      prev = led_adc;
      repeat (20) begin
         @(negedge clk_usb_buf);
         check_value("led_adc_o", led_adc, flash_ref[FLASH_DIV_BITS-1]);
         check_value("led_glitch_o", led_glitch, flash_ref[FLASH_DIV_BITS-1]);
         if (led_adc !== prev) begin
            toggles++;
         end
         prev = led_adc;
      end
      assert (toggles >= 2) else begin
         $display("led_adc_o toggled only %0d times in 20 cycles with an error pending",
                  toggles);
         errors++;
      end
   endtask

   task automatic check_leds(input logic [7:0] mode, input logic [7:0] exp);
      if (mode[0]) begin
         check_flash();
      end else begin
         @(negedge clk_usb_buf);
         check_value("led_adc_o", led_adc, exp[0]);
         check_value("led_glitch_o", led_glitch, exp[1]);
         check_value("led_cap_o", led_cap_out, exp[2]);
         check_value("led_armed_o", led_armed_out, exp[3]);
      end
   endtask

   initial begin
      int unsigned seed_ret;
      int unsigned n_ops;
      int unsigned idx;
      int unsigned err_before;
      logic [7:0]  op;
      logic [7:0]  arg;
      logic [7:0]  val;
      seed_ret     = $urandom(32'ha669);
      errors       = 0;
      tests_failed = 0;
      cycles       = 0;
      cycle_limit  = 0;
      rst_n        = 1'b0;
      reg_address  = '0;
      write_data   = '0;
      reg_write    = 1'b0;
      reg_read     = 1'b0;
      fifo_dout    = '0;
      error_pulse  = '0;
      drive_pins(8'h00);
      for (idx = 0; idx < STIM_DEPTH; idx++) begin
         stim_mem[idx] = OP_END;
      end
      $readmemh("husky_stimulus.txt", stim_mem);
      n_ops = 0;
      while (n_ops < STIM_DEPTH / 3 && stim_mem[n_ops * 3] != OP_END) begin
         n_ops++;
      end
      cycle_limit = CYCLES_PER_LINE * (n_ops + 1);  // One extra line's worth for reset
      repeat (4) @(posedge clk_usb_buf);
      #(DRIVE_DLY) rst_n = 1'b1;
      for (idx = 0; idx < n_ops; idx++) begin
         @(posedge clk_usb_buf);
         #(DRIVE_DLY);
         fifo_dout  = $urandom;
         reg_read   = 1'b0;
         op         = stim_mem[idx * 3];
         arg        = stim_mem[idx * 3 + 1];
         val        = stim_mem[idx * 3 + 2];
         err_before = errors;
         case (op)
            OP_WRITE:      bus_write(arg, val);
            OP_READ:       bus_read(arg, val);
            OP_PULSE_ERR:  pulse_error(arg);
            OP_SET_PINS:   drive_pins(arg);
            OP_CHECK_PINS: check_pins(arg, val);
            OP_CHECK_LED:  check_leds(arg, val);
            default: begin
               $display("Stimulus line %0d holds an unknown opcode %h", idx, op);
               errors++;
            end
         endcase
         if (errors == err_before) begin
            $display("Test %0d (%h %h %h) passed", idx, op, arg, val);
         end else begin
            $display("Test %0d (%h %h %h) FAILED", idx, op, arg, val);
            tests_failed++;
         end
      end
      $display("Tests run %0d, failed %0d, check errors %0d", n_ops, tests_failed, errors);
      if (errors == 0) begin
         $display("Simulation completed successfully");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

/* husky_stimulus.txt */
// Columns: opcode arg data. 01 write addr data, 02 read addr expected, 03 pulse-error bits --
// 04 set-pins inputs --, 05 check-pins z-mask values, 06 check-LED flash expected
05 3f 00
06 00 01
02 24 10
01 24 a5
02 24 a5
01 25 5a
02 25 5a
01 27 c3
02 27 c3
02 40 00
02 03 00
02 26 00
01 25 05
01 24 0e
04 0f 00
05 38 45
01 24 01
04 0a 00
05 06 68
04 05 00
05 06 51
01 24 11
05 1f 00
01 24 00
05 3f 40
04 10 00
06 00 02
04 70 00
06 00 0e
03 02 00
02 26 02
06 01 00
01 26 02
02 26 00
06 00 0e
03 05 00
02 26 05
01 26 01
02 26 04
06 01 00
01 26 04
02 26 00
06 00 0e
ff 00 00

/* src.f */
husky_pkg.sv
target_io_regs.sv
status_regs.sv
read_combine.sv
target_pin_router.sv
led_driver.sv
husky_ctrl_top.sv
tb_husky_ctrl.sv

/* Bender.yml */
package:
  name: husky_ctrl

sources:
  - husky_pkg.sv
  - target_io_regs.sv
  - status_regs.sv
  - read_combine.sv
  - target_pin_router.sv
  - led_driver.sv
  - husky_ctrl_top.sv
  - target: simulation
    files:
      - tb_husky_ctrl.sv
